/* design/flash_cmd_decode.sv */
`timescale 1ns/1ns

module flash_cmd_decode import flash_pkg::*; (
	input logic [7:0] opcode,
	output cmd_desc_t desc
);
	always_comb begin
		// anything not listed below is flagged
		desc = '{kind: CMD_BAD, needs_addr: 1'b0, needs_wel: 1'b0, is_bad: 1'b1};

		case (opcode)
			OP_READ: begin
				desc = '{kind: CMD_READ, needs_addr: 1'b1, needs_wel: 1'b0, is_bad: 1'b0};
			end
			OP_PP: begin
				desc = '{kind: CMD_PROGRAM, needs_addr: 1'b1, needs_wel: 1'b1, is_bad: 1'b0};
			end
			OP_ERASE: begin
				// 4 KB sector, address picks the sector
				desc = '{kind: CMD_ERASE, needs_addr: 1'b1, needs_wel: 1'b1, is_bad: 1'b0};
			end
			OP_WREN: begin
				desc = '{kind: CMD_WREN, needs_addr: 1'b0, needs_wel: 1'b0, is_bad: 1'b0};
			end
			OP_WRDS: begin
				desc = '{kind: CMD_WRDS, needs_addr: 1'b0, needs_wel: 1'b0, is_bad: 1'b0};
			end
			OP_RDSR: begin
				desc = '{kind: CMD_RDSR, needs_addr: 1'b0, needs_wel: 1'b0, is_bad: 1'b0};
			end
			OP_RDID: begin
				desc = '{kind: CMD_RDID, needs_addr: 1'b0, needs_wel: 1'b0, is_bad: 1'b0};
			end
			default: begin
				desc.is_bad = 1'b1;
			end
		endcase
	end

endmodule

/* design/flash_cmd_execute.sv */
`timescale 1ns/1ns

module flash_cmd_execute import flash_pkg::*; (
	input logic clk,
	input logic reset,
	input spi_rx_t rx,
	input cmd_desc_t desc,
	input ram_rsp_t ram_rsp,
	output logic tx_load,
	output logic [7:0] tx_byte,
	output logic miso_oe,
	output ram_req_t ram_req,
	output logic busy,
	output logic wel,
	output logic error
);
	cmd_t cur_kind;
	logic need_addr;
	// address bytes seen and the id byte index for rdid
	logic [1:0] addr_cnt;
	logic [MEM_ADDR_BITS-1:0] addr;
	logic [MEM_ADDR_BITS-1:0] addr_in;
	logic [MEM_ADDR_BITS-1:0] addr_next;
	logic outstanding;

	// read path
	logic [1:0] load_wait;
	logic [15:0] buf_word;
	logic buf_valid;
	logic [15:0] word_sel;

	// background erase
	logic erase_pend;
	logic erase_run;
	logic [MEM_ADDR_BITS-2:0] erase_word;

	logic cmd_ok;
	logic [7:0] status;

	assign status = {6'd0, wel, busy};
	assign addr_in = {addr[MEM_ADDR_BITS-9:0], rx.data};
	assign addr_next = addr + 1'b1;
	// the word arriving this cycle wins over the buffered one
	assign word_sel = ram_rsp.valid ? ram_rsp.rdata : buf_word;
	// status stays readable during an erase
	assign cmd_ok = (desc.kind == CMD_RDSR) || (!busy && (!desc.needs_wel || wel));

	always_ff @(posedge clk) begin
		if (reset) begin
			cur_kind <= CMD_IDLE;
			need_addr <= 1'b0;
			addr_cnt <= '0;
			addr <= '0;
			outstanding <= 1'b0;
			load_wait <= '0;
			buf_word <= '0;
			buf_valid <= 1'b0;
			erase_pend <= 1'b0;
			erase_run <= 1'b0;
			erase_word <= '0;
			tx_load <= 1'b0;
			tx_byte <= '0;
			miso_oe <= 1'b0;
			ram_req <= '0;
			busy <= 1'b0;
			wel <= 1'b0;
			error <= 1'b0;
		end else begin
			tx_load <= 1'b0;
			ram_req.strobe <= 1'b0;
			outstanding <= (outstanding && !ram_rsp.valid) || ram_req.strobe;

			// erase one word at a time and send the next word on each write answer
			if (erase_run) begin
				if (ram_rsp.valid) begin
					if ((erase_word & 12'(SECTOR_WORDS - 1)) == 12'(SECTOR_WORDS - 1)) begin
						erase_run <= 1'b0;
						busy <= 1'b0;
						wel <= 1'b0;
					end else begin
						erase_word <= erase_word + 1'b1;
						ram_req <= '{strobe: 1'b1, write: 1'b1, addr: erase_word + 1'b1,
							mask: 2'b11, wdata: 16'hFFFF};
					end
				end else if (!outstanding && !ram_req.strobe) begin
					// first word of the sector
					ram_req <= '{strobe: 1'b1, write: 1'b1, addr: erase_word,
						mask: 2'b11, wdata: 16'hFFFF};
				end
			end

			// keep the fetched word for the second byte
			if (ram_rsp.valid && cur_kind == CMD_READ) begin
				buf_word <= ram_rsp.rdata;
				buf_valid <= 1'b1;
			end

			// read byte goes out 4 cycles after the strobe
			if (load_wait > 2'd1) begin
				load_wait <= load_wait - 2'd1;
			end else if (load_wait == 2'd1 && (buf_valid || ram_rsp.valid)) begin
				load_wait <= '0;
				tx_load <= 1'b1;
				tx_byte <= addr[0] ? word_sel[15:8] : word_sel[7:0];
				addr <= addr_next;
				if (addr[0]) begin
					// prefetch the next word
					ram_req <= '{strobe: 1'b1, write: 1'b0,
						addr: addr_next[MEM_ADDR_BITS-1:1], mask: 2'b00, wdata: 16'h0};
					buf_valid <= 1'b0;
				end
			end

			if (!rx.cs_active) begin
				// end of transaction where a finished program drops the latch
				if (cur_kind == CMD_PROGRAM)
					wel <= 1'b0;
				if (erase_pend) begin
					erase_pend <= 1'b0;
					erase_run <= 1'b1;
					busy <= 1'b1;
				end
				cur_kind <= CMD_IDLE;
				need_addr <= 1'b0;
				addr_cnt <= '0;
				load_wait <= '0;
				miso_oe <= 1'b0;
			end else if (rx.strobe && rx.first) begin
				// opcode byte
				cur_kind <= CMD_IDLE;
				need_addr <= 1'b0;
				addr_cnt <= '0;
				load_wait <= '0;
				erase_pend <= 1'b0;
				// a read while busy still drives miso with ones
				miso_oe <= desc.kind inside {CMD_READ, CMD_RDSR, CMD_RDID};

				if (desc.is_bad) begin
					error <= 1'b1;
				end else if (cmd_ok) begin
					cur_kind <= desc.kind;
					need_addr <= desc.needs_addr;
					case (desc.kind)
						CMD_WREN: wel <= 1'b1;
						CMD_WRDS: wel <= 1'b0;
						CMD_RDSR: begin
							tx_load <= 1'b1;
							tx_byte <= status;
						end
						CMD_RDID: begin
							tx_load <= 1'b1;
							tx_byte <= JEDEC_ID[23:16];
							addr_cnt <= 2'd1;
						end
						default: begin
						end
					endcase
				end
			end else if (rx.strobe) begin
				if (need_addr && addr_cnt != 2'd3) begin
					// address comes msb first and the upper bits fall off
					addr <= addr_in;
					addr_cnt <= addr_cnt + 2'd1;
					if (addr_cnt == 2'd2) begin
						if (cur_kind == CMD_READ) begin
							ram_req <= '{strobe: 1'b1, write: 1'b0,
								addr: addr_in[MEM_ADDR_BITS-1:1], mask: 2'b00, wdata: 16'h0};
							buf_valid <= 1'b0;
							load_wait <= 2'd3;
						end
						if (cur_kind == CMD_ERASE) begin
							erase_pend <= 1'b1;
							erase_word <= addr_in[MEM_ADDR_BITS-1:1] & ~12'(SECTOR_WORDS - 1);
						end
					end
				end else begin
					case (cur_kind)
						CMD_READ: load_wait <= 2'd3;
						CMD_PROGRAM: begin
							// byte lane from address bit 0
							ram_req <= '{strobe: 1'b1, write: 1'b1,
								addr: addr[MEM_ADDR_BITS-1:1],
								mask: addr[0] ? 2'b10 : 2'b01,
								wdata: {rx.data, rx.data}};
							// stays inside the 256 byte page
							addr <= {addr[MEM_ADDR_BITS-1:8], addr[7:0] + 8'd1};
						end
						CMD_RDSR: begin
							tx_load <= 1'b1;
							tx_byte <= status;
						end
						CMD_RDID: begin
							if (addr_cnt != 2'd3) begin
								tx_load <= 1'b1;
								tx_byte <= (addr_cnt == 2'd1) ?
									JEDEC_ID[15:8] : JEDEC_ID[7:0];
								addr_cnt <= addr_cnt + 2'd1;
							end
						end
						default: begin
						end
					endcase
				end
			end
		end
	end

	// memory takes one request at a time
	a_one_outstanding: assert property (@(posedge clk) disable iff (reset)
		ram_req.strobe |-> !outstanding);

	// erase only starts with the latch set
	a_busy_needs_wel: assert property (@(posedge clk) disable iff (reset)
		$rose(busy) |-> $past(wel));

endmodule

/* design/flash_pkg.sv */
package flash_pkg;

	// serial flash opcodes
	localparam logic [7:0] OP_PP = 8'h02;
	localparam logic [7:0] OP_READ = 8'h03;
	localparam logic [7:0] OP_WRDS = 8'h04;
	localparam logic [7:0] OP_RDSR = 8'h05;
	localparam logic [7:0] OP_WREN = 8'h06;
	localparam logic [7:0] OP_ERASE = 8'h20;
	localparam logic [7:0] OP_RDID = 8'h9F;

	// 8 KB array, two 4 KB sectors
	localparam int MEM_ADDR_BITS = 13;
	localparam int MEM_WORDS = 4096;
	localparam int SECTOR_BYTES = 4096;
	localparam int SECTOR_WORDS = SECTOR_BYTES / 2;

	// manufacturer, type, capacity
	localparam logic [23:0] JEDEC_ID = 24'hC22018;

	// request strobe to read valid
	localparam int RAM_LATENCY = 2;

	typedef enum logic [3:0] {
		CMD_IDLE,
		CMD_READ,
		CMD_PROGRAM,
		CMD_ERASE,
		CMD_WREN,
		CMD_WRDS,
		CMD_RDSR,
		CMD_RDID,
		CMD_BAD
	} cmd_t;

	typedef struct packed {
		cmd_t kind;
		logic needs_addr;
		// write-enable latch must be set
		logic needs_wel;
		logic is_bad;
	} cmd_desc_t;

	typedef struct packed {
		logic [7:0] data;
		// first byte after cs_n fell
		logic first;
		logic strobe;
		logic cs_active;
	} spi_rx_t;

	typedef struct packed {
		logic strobe;
		logic write;
		// word address
		logic [MEM_ADDR_BITS-2:0] addr;
		// bit 1 is the upper byte
		logic [1:0] mask;
		logic [15:0] wdata;
	} ram_req_t;

	typedef struct packed {
		logic valid;
		logic [15:0] rdata;
	} ram_rsp_t;

endpackage

/* design/flash_word_ram.sv */
`timescale 1ns/1ns

module flash_word_ram import flash_pkg::*; (
	input logic clk,
	input logic reset,
	input ram_req_t req,
	output ram_rsp_t rsp
);
	logic [15:0] mem [MEM_WORDS];

	// valid and data travel together through the latency pipe
	logic [RAM_LATENCY-1:0] valid_pipe;
	logic [15:0] data_pipe [RAM_LATENCY];

	// byte lanes written under the mask
	always_ff @(posedge clk) begin
		if (req.strobe && req.write) begin
			if (req.mask[0])
				mem[req.addr][7:0] <= req.wdata[7:0];
			if (req.mask[1])
				mem[req.addr][15:8] <= req.wdata[15:8];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_pipe <= '0;
			for (int i = 0; i < RAM_LATENCY; i++)
				data_pipe[i] <= '0;
		end else begin
			// writes answer too, with don't care data
			valid_pipe <= {valid_pipe[RAM_LATENCY-2:0], req.strobe};
			if (req.strobe)
				data_pipe[0] <= mem[req.addr];
			for (int i = 1; i < RAM_LATENCY; i++)
				data_pipe[i] <= data_pipe[i-1];
		end
	end

	assign rsp.valid = valid_pipe[RAM_LATENCY-1];
	assign rsp.rdata = data_pipe[RAM_LATENCY-1];

	// every answer belongs to a request exactly RAM_LATENCY back
	a_valid_after_req: assert property (@(posedge clk) disable iff (reset)
		rsp.valid |-> $past(req.strobe, RAM_LATENCY));

endmodule

/* design/spi_flash_top.sv */
`timescale 1ns/1ns

module spi_flash_top import flash_pkg::*; (
	input logic clk,
	input logic reset,
	input logic sck,
	input logic cs_n,
	input logic mosi,
	output logic miso,
	output logic miso_oe,
	output logic busy,
	output logic wel,
	output logic error
);
	spi_rx_t rx;
	cmd_desc_t desc;
	ram_req_t ram_req;
	ram_rsp_t ram_rsp;
	logic tx_load;
	logic [7:0] tx_byte;

	// pins, byte assembly and transmit shifter
	spi_shift_port u_port (
		.clk(clk),
		.reset(reset),
		.sck(sck),
		.cs_n(cs_n),
		.mosi(mosi),
		.tx_load(tx_load),
		.tx_byte(tx_byte),
		.miso(miso),
		.rx(rx)
	);

	// opcode classification on the raw byte
	flash_cmd_decode u_decode (
		.opcode(rx.data),
		.desc(desc)
	);

	flash_cmd_execute u_execute (
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.desc(desc),
		.ram_rsp(ram_rsp),
		.tx_load(tx_load),
		.tx_byte(tx_byte),
		.miso_oe(miso_oe),
		.ram_req(ram_req),
		.busy(busy),
		.wel(wel),
		.error(error)
	);

	flash_word_ram u_ram (
		.clk(clk),
		.reset(reset),
		.req(ram_req),
		.rsp(ram_rsp)
	);

endmodule

/* design/spi_shift_port.sv */
`timescale 1ns/1ns

module spi_shift_port import flash_pkg::*; (
	input logic clk,
	input logic reset,
	input logic sck,
	input logic cs_n,
	input logic mosi,
	input logic tx_load,
	input logic [7:0] tx_byte,
	output logic miso,
	output spi_rx_t rx
);
	// two flop synchronizers, index 1 is the stable copy
	logic [1:0] sck_sync;
	logic [1:0] cs_sync;
	logic [1:0] mosi_sync;
	logic sck_last;
	logic sck_rise;
	logic sck_fall;
	logic cs_on;

	logic [2:0] bit_cnt;
	logic [6:0] rx_shift;
	logic first_pend;
	logic [7:0] tx_shift;

	assign sck_rise = sck_sync[1] && !sck_last;
	assign sck_fall = !sck_sync[1] && sck_last;
	assign cs_on = !cs_sync[1];

	// msb goes out first
	assign miso = tx_shift[7];

	always_ff @(posedge clk) begin
		if (reset) begin
			sck_sync <= '0;
			cs_sync <= '1;
			mosi_sync <= '0;
			sck_last <= 1'b0;
			bit_cnt <= '0;
			rx_shift <= '0;
			first_pend <= 1'b0;
			tx_shift <= 8'hFF;
			rx <= '0;
		end else begin
			sck_sync <= {sck_sync[0], sck};
			cs_sync <= {cs_sync[0], cs_n};
			mosi_sync <= {mosi_sync[0], mosi};
			sck_last <= sck_sync[1];

			rx.strobe <= 1'b0;
			rx.cs_active <= cs_on;

			if (!cs_on) begin
				// idle bus, next byte opens a transaction
				bit_cnt <= '0;
				first_pend <= 1'b1;
				tx_shift <= 8'hFF;
			end else begin
				if (sck_rise) begin
					// mode 0, sample on the rising edge
					bit_cnt <= bit_cnt + 3'd1;
					rx_shift <= {rx_shift[5:0], mosi_sync[1]};
					if (bit_cnt == 3'd7) begin
						rx.strobe <= 1'b1;
						rx.data <= {rx_shift, mosi_sync[1]};
						rx.first <= first_pend;
						first_pend <= 1'b0;
						// ones unless the sequencer loads a byte
						tx_shift <= 8'hFF;
					end
				end else if (sck_fall && bit_cnt != 3'd0) begin
					// the fall after a byte boundary keeps bit 7 in place
					tx_shift <= {tx_shift[6:0], 1'b1};
				end

				if (tx_load)
					tx_shift <= tx_byte;
			end
		end
	end

	// a byte can only complete inside a transaction
	a_rx_in_cs: assert property (@(posedge clk) disable iff (reset)
		rx.strobe |-> rx.cs_active);

endmodule

/* list.f */
design/flash_pkg.sv
design/spi_shift_port.sv
design/flash_cmd_decode.sv
design/flash_cmd_execute.sv
design/flash_word_ram.sv
design/spi_flash_top.sv
sim/spi_flash_tb.sv
+incdir+sim

/* run.sh */
#!/usr/bin/env bash
# build the spi flash testbench with verilator and run it
set -eo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	--top-module spi_flash_tb \
	-f list.f \
	-o spi_flash_sim

./obj_dir/spi_flash_sim | tee sim.log

if grep -q "TEST FAIL" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished without failures"

/* sim/spi_flash_tb_table.svh */
`ifndef SPI_FLASH_TB_TABLE_SVH
`define SPI_FLASH_TB_TABLE_SVH

// columns: opcode, 24-bit address, data byte count, expected status or id bytes
typedef struct packed {
	logic [7:0] op;
	logic [23:0] addr;
	logic [15:0] count;
	logic [23:0] exp_val;
} step_t;

localparam int STEP_COUNT = 32;

localparam step_t STEP_TABLE [STEP_COUNT] = '{
	// straight out of reset
	'{OP_RDSR, 24'h000000, 16'd1, 24'h000000},
	'{OP_RDID, 24'h000000, 16'd3, 24'hC22018},
	// latch on and off, seen in status bit 1
	'{OP_WREN, 24'h000000, 16'd0, 24'h000000},
	'{OP_RDSR, 24'h000000, 16'd1, 24'h000002},
	'{OP_WRDS, 24'h000000, 16'd0, 24'h000000},
	'{OP_RDSR, 24'h000000, 16'd1, 24'h000000},
	// blank sector 0 before anything reads it
	'{OP_WREN, 24'h000000, 16'd0, 24'h000000},
	'{OP_ERASE, 24'h000000, 16'd0, 24'h000000},
	'{OP_RDSR, 24'h000000, 16'd1, 24'h000000},
	// 16 bytes at an odd address, latch gone afterwards
	'{OP_WREN, 24'h000000, 16'd0, 24'h000000},
	'{OP_PP, 24'h000101, 16'd16, 24'h000000},
	'{OP_RDSR, 24'h000000, 16'd1, 24'h000000},
	'{OP_READ, 24'h0000FF, 16'd20, 24'h000000},
	// the second program has no latch and must not land
	'{OP_WREN, 24'h000000, 16'd0, 24'h000000},
	'{OP_PP, 24'h000200, 16'd8, 24'h000000},
	'{OP_PP, 24'h000200, 16'd8, 24'h000000},
	'{OP_READ, 24'h0001FE, 16'd12, 24'h000000},
	// odd start, many word boundaries
	'{OP_READ, 24'h0000F5, 16'd40, 24'h000000},
	// data in sector 1, then erase that sector
	'{OP_WREN, 24'h000000, 16'd0, 24'h000000},
	'{OP_PP, 24'h001234, 16'd16, 24'h000000},
	'{OP_READ, 24'h001234, 16'd16, 24'h000000},
	'{OP_WREN, 24'h000000, 16'd0, 24'h000000},
	'{OP_ERASE, 24'h001000, 16'd0, 24'h000000},
	'{OP_READ, 24'h001000, 16'd4096, 24'h000000},
	'{OP_READ, 24'h000100, 16'd32, 24'h000000},
	// upper address bits fall off, stream wraps to 0
	'{OP_READ, 24'h003FFE, 16'd4, 24'h000000},
	// unknown opcode, error sticks
	'{8'hAB, 24'h000000, 16'd0, 24'h000000},
	'{OP_RDSR, 24'h000000, 16'd1, 24'h000000},
	'{OP_RDID, 24'h000000, 16'd3, 24'hC22018},
	'{OP_WREN, 24'h000000, 16'd0, 24'h000000},
	'{OP_RDSR, 24'h000000, 16'd1, 24'h000002},
	'{OP_WRDS, 24'h000000, 16'd0, 24'h000000}
};

`endif

/* sim/spi_flash_tb.sv */
`timescale 1ns/1ns

module spi_flash_tb import flash_pkg::*; ();

	`include "spi_flash_tb_table.svh"

	// status reads allowed while an erase runs
	localparam int POLL_LIMIT = 200;

	logic clk;
	logic reset;
	logic sck;
	logic cs_n;
	logic mosi;
	logic miso;
	logic miso_oe;
	logic busy;
	logic wel;
	logic error;

	// byte image of the 8 KB array
	logic [7:0] ref_mem [8192];
	logic model_wel;
	logic model_error;

	int step_errors;
	int pass_count;
	int fail_count;
	int cycles = 0;
	int cycle_limit = 0;

	spi_flash_top u_dut (
		.clk(clk),
		.reset(reset),
		.sck(sck),
		.cs_n(cs_n),
		.mosi(mosi),
		.miso(miso),
		.miso_oe(miso_oe),
		.busy(busy),
		.wel(wel),
		.error(error)
	);

	always #50 clk = ~clk;

	// hard stop once the run outgrows the table
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("timeout: the run went past %0d clock cycles", cycle_limit);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic wait_clocks(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic note_mismatch(input string sig, input logic [7:0] exp_b,
			input logic [7:0] act_b);
		$display("[ERROR] %0t ns %s expected %h actual %h", $time, sig, exp_b, act_b);
		step_errors++;
	endtask

	task automatic flag_failure(input string what);
		$display("failure at %0t ns: %s", $time, what);
		step_errors++;
	endtask

	// mode 0 with each sck level held 8 clk and miso taken just before the rise
	task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx_byte,
			output logic oe_held);
		rx_byte = 8'h00;
		oe_held = 1'b1;
		for (int i = 7; i >= 0; i--) begin
			mosi = tx[i];
			wait_clocks(8);
			rx_byte[i] = miso;
			oe_held = oe_held & miso_oe;
			sck = 1'b1;
			wait_clocks(8);
			sck = 1'b0;
		end
	endtask

	task automatic open_cs();
		cs_n = 1'b0;
		wait_clocks(8);
	endtask

	// gap long enough for the synchronized cs_n to reach the sequencer
	task automatic close_cs();
		wait_clocks(4);
		cs_n = 1'b1;
		mosi = 1'b0;
		wait_clocks(16);
	endtask

	task automatic read_status(output logic [7:0] st);
		logic [7:0] unused_byte;
		logic oe;
		open_cs();
		shift_byte(OP_RDSR, unused_byte, oe);
		shift_byte(8'h00, st, oe);
		close_cs();
	endtask

	// busy has to show up and then drop
	task automatic wait_erase();
		logic [7:0] st;
		logic seen_busy;
		int polls;
		st = 8'h01;
		seen_busy = 1'b0;
		polls = 0;
		while (st[0] && polls < POLL_LIMIT) begin
			read_status(st);
			polls++;
			if (st[0])
				seen_busy = 1'b1;
		end
		if (st[0])
			flag_failure($sformatf("busy still set after %0d status reads", polls));
		if (!seen_busy)
			flag_failure("busy was never seen set in the status byte during the erase");
	endtask

	task automatic run_step(input step_t step);
		logic [7:0] rx_byte;
		logic [7:0] exp_byte;
		logic [7:0] data [$];
		logic [12:0] a;
		logic [12:0] at;
		logic oe;
		logic with_addr;
		logic returns_data;

		a = step.addr[12:0];
		with_addr = step.op inside {OP_READ, OP_PP, OP_ERASE};
		returns_data = step.op inside {OP_READ, OP_RDSR, OP_RDID};

		open_cs();
		shift_byte(step.op, rx_byte, oe);
		if (with_addr) begin
			shift_byte(step.addr[23:16], rx_byte, oe);
			shift_byte(step.addr[15:8], rx_byte, oe);
			shift_byte(step.addr[7:0], rx_byte, oe);
		end
		for (int i = 0; i < int'(step.count); i++) begin
			if (step.op == OP_PP) begin
				exp_byte = 8'($urandom);
				data.push_back(exp_byte);
				shift_byte(exp_byte, rx_byte, oe);
			end else begin
				shift_byte(8'h00, rx_byte, oe);
				// stream address wraps inside 8 KB
				at = a + 13'(i);
				case (step.op)
					OP_READ: exp_byte = ref_mem[at];
					OP_RDSR: exp_byte = step.exp_val[7:0];
					OP_RDID: exp_byte = step.exp_val[23 - 8 * i -: 8];
					default: exp_byte = 8'hFF;
				endcase
				if (rx_byte !== exp_byte)
					note_mismatch($sformatf("miso byte %0d at %h", i, at),
						exp_byte, rx_byte);
				if (returns_data && oe !== 1'b1)
					note_mismatch("miso_oe", 8'h01, {7'd0, oe});
			end
		end
		close_cs();

		// reference model follows the accepted commands
		case (step.op)
			OP_WREN: model_wel = 1'b1;
			OP_WRDS: model_wel = 1'b0;
			OP_PP: begin
				if (model_wel) begin
					foreach (data[i]) begin
						// page wrap keeps the upper address bits
						at = {a[12:8], a[7:0] + 8'(i)};
						ref_mem[at] = data[i];
					end
					model_wel = 1'b0;
				end
			end
			OP_ERASE: begin
				if (model_wel) begin
					for (int j = 0; j < 4096; j++)
						ref_mem[{a[12], 12'(j)}] = 8'hFF;
					model_wel = 1'b0;
					wait_erase();
				end
			end
			OP_READ, OP_RDSR, OP_RDID: begin
			end
			default: model_error = 1'b1;
		endcase

		if (wel !== model_wel)
			note_mismatch("wel", {7'd0, model_wel}, {7'd0, wel});
		if (error !== model_error)
			note_mismatch("error", {7'd0, model_error}, {7'd0, error});
		if (busy !== 1'b0)
			note_mismatch("busy", 8'h00, {7'd0, busy});
	endtask

	initial begin
		int bytes;

		clk = 1'b0;
		reset = 1'b1;
		sck = 1'b0;
		cs_n = 1'b1;
		mosi = 1'b0;
		model_wel = 1'b0;
		model_error = 1'b0;
		pass_count = 0;
		fail_count = 0;
		void'($urandom(32'hd035));

		// 16 clk per SPI bit plus the cs gaps and a fixed budget per erase
		cycle_limit = 1000;
		for (int s = 0; s < STEP_COUNT; s++) begin
			bytes = 1 + int'(STEP_TABLE[s].count);
			if (STEP_TABLE[s].op inside {OP_READ, OP_PP, OP_ERASE})
				bytes = bytes + 3;
			cycle_limit = cycle_limit + bytes * 8 * 16 + 28;
			if (STEP_TABLE[s].op == OP_ERASE)
				cycle_limit = cycle_limit + 8000;
		end

		wait_clocks(16);
		reset = 1'b0;
		wait_clocks(4);

		for (int s = 0; s < STEP_COUNT; s++) begin
			step_errors = 0;
			run_step(STEP_TABLE[s]);
			if (step_errors == 0) begin
				pass_count++;
				$display("step %0d op %h addr %h: ok", s, STEP_TABLE[s].op,
					STEP_TABLE[s].addr);
			end else begin
				fail_count++;
				$display("step %0d op %h addr %h: %0d errors", s, STEP_TABLE[s].op,
					STEP_TABLE[s].addr, step_errors);
			end
		end

		$display("steps passed %0d, steps failed %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
